//--- project.f
design/cpu_pkg.sv
design/alu.sv
design/register_file.sv
design/program_memory.sv
design/datapath_regs.sv
design/bus_mux.sv
design/control_unit.sv
design/cpu_top.sv
tb/cpu_properties.sv
tb/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu_microcode

sources:
  - design/cpu_pkg.sv
  - design/alu.sv
  - design/register_file.sv
  - design/program_memory.sv
  - design/datapath_regs.sv
  - design/bus_mux.sv
  - design/control_unit.sv
  - design/cpu_top.sv
  - target: simulation
    files:
      - tb/cpu_properties.sv
      - tb/cpu_tb.sv

//--- tb/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int TIMEOUT_CYCLES = 20;

    // one program word and what it should leave behind
    typedef struct packed {
        data_t     word;
        logic      wr_en;
        reg_addr_t wr_addr;
        data_t     wr_data;
        flags_t    flags;       // {zero, carry}
        int        cycles;      // fetch entry to next fetch entry
    } step_t;

    logic      i_w_clk;
    logic      i_w_reset;
    logic      i_w_load_en;
    mem_addr_t i_w_load_addr;
    data_t     i_w_load_data;
    state_t    o_w_state_disp_out;
    flags_t    o_w_flags;
    logic      o_w_reg_wr_en;
    reg_addr_t o_w_reg_wr_addr;
    data_t     o_w_reg_wr_data;

    step_t     steps_q[$];
    string     names_q[$];

    cpu_top cpu_top_inst (
        .i_w_clk            (i_w_clk),
        .i_w_reset          (i_w_reset),
        .i_w_load_en        (i_w_load_en),
        .i_w_load_addr      (i_w_load_addr),
        .i_w_load_data      (i_w_load_data),
        .o_w_state_disp_out (o_w_state_disp_out),
        .o_w_flags          (o_w_flags),
        .o_w_reg_wr_en      (o_w_reg_wr_en),
        .o_w_reg_wr_addr    (o_w_reg_wr_addr),
        .o_w_reg_wr_data    (o_w_reg_wr_data)
    );

    always #5 i_w_clk = ~i_w_clk;

    // register-direct one-operand word: 0001 op, mod 11, target in rm
    function automatic data_t one_op(input logic [2:0] op, input reg_addr_t rm);
        return {4'b0001, op, 1'b0, 2'b11, 3'b000, rm};
    endfunction

    // register-direct two-operand word, store bit clear for cmp/test
    function automatic data_t two_op(input logic store, input logic [2:0] op, input logic d,
                                     input reg_addr_t rg, input reg_addr_t rm);
        return {3'b010, store, op, d, 2'b11, rg, rm};
    endfunction

    task automatic add_step(input string name, input data_t word, input logic wr_en,
                            input reg_addr_t wr_addr, input data_t wr_data,
                            input flags_t flags, input int cycles);
        step_t st;
        st.word    = word;
        st.wr_en   = wr_en;
        st.wr_addr = wr_addr;
        st.wr_data = wr_data;
        st.flags   = flags;
        st.cycles  = cycles;
        steps_q.push_back(st);
        names_q.push_back(name);
    endtask

    // names are dst,src; all registers start at zero
    task automatic build_table;
        add_step("inc ra", one_op(3'd0, REG_RA), 1'b1, REG_RA, 16'h0001, 2'b00, 9);
        add_step("dec rb", one_op(3'd1, REG_RB), 1'b1, REG_RB, 16'hffff, 2'b01, 9);
        add_step("dec ra", one_op(3'd1, REG_RA), 1'b1, REG_RA, 16'h0000, 2'b10, 9);
        add_step("inc ra again", one_op(3'd0, REG_RA), 1'b1, REG_RA, 16'h0001, 2'b00, 9);
        add_step("add rc,rb", two_op(1'b1, 3'd0, 1'b0, REG_RB, REG_RC),
                 1'b1, REG_RC, 16'hffff, 2'b00, 10);
        add_step("add rc,ra", two_op(1'b1, 3'd0, 1'b1, REG_RC, REG_RA),
                 1'b1, REG_RC, 16'h0000, 2'b11, 10);        // ffff + 1 wraps
        add_step("adc is,ra", two_op(1'b1, 3'd1, 1'b0, REG_RA, REG_IS),
                 1'b1, REG_IS, 16'h0002, 2'b00, 10);        // 0 + 1 + stored carry
        add_step("sub xa,is", two_op(1'b1, 3'd2, 1'b0, REG_IS, REG_XA),
                 1'b1, REG_XA, 16'hfffe, 2'b01, 10);
        add_step("sbb xb,is", two_op(1'b1, 3'd3, 1'b1, REG_XB, REG_IS),
                 1'b1, REG_XB, 16'hfffd, 2'b01, 10);        // 0 - 2 - borrow
        add_step("sub xa,xb", two_op(1'b1, 3'd2, 1'b1, REG_XA, REG_XB),
                 1'b1, REG_XA, 16'h0001, 2'b00, 10);
        add_step("neg is", one_op(3'd2, REG_IS), 1'b1, REG_IS, 16'hfffe, 2'b01, 9);
        add_step("not ra", one_op(3'd3, REG_RA), 1'b1, REG_RA, 16'hfffe, 2'b00, 9);
        add_step("shl rb", one_op(3'd4, REG_RB), 1'b1, REG_RB, 16'hfffe, 2'b01, 9);
        add_step("shr is", one_op(3'd5, REG_IS), 1'b1, REG_IS, 16'h7fff, 2'b00, 9);
        add_step("sar xb", one_op(3'd6, REG_XB), 1'b1, REG_XB, 16'hfffe, 2'b01, 9);
        add_step("shr xa", one_op(3'd5, REG_XA), 1'b1, REG_XA, 16'h0000, 2'b11, 9);
        add_step("and ra,is", two_op(1'b1, 3'd4, 1'b0, REG_IS, REG_RA),
                 1'b1, REG_RA, 16'h7ffe, 2'b00, 10);
        add_step("or ba,rb", two_op(1'b1, 3'd5, 1'b1, REG_BA, REG_RB),
                 1'b1, REG_BA, 16'hfffe, 2'b00, 10);
        add_step("xor ba,ra", two_op(1'b1, 3'd6, 1'b0, REG_RA, REG_BA),
                 1'b1, REG_BA, 16'h8000, 2'b00, 10);
        add_step("cmp is,ba", two_op(1'b0, 3'd2, 1'b0, REG_BA, REG_IS),
                 1'b0, REG_RA, 16'h0000, 2'b01, 9);         // flags only
        add_step("test ra,xa", two_op(1'b0, 3'd4, 1'b0, REG_XA, REG_RA),
                 1'b0, REG_RA, 16'h0000, 2'b10, 9);
        add_step("inc mem operand", 16'h1000, 1'b0, REG_RA, 16'h0000, 2'b10, 6);
        add_step("unknown word", 16'hf4c0, 1'b0, REG_RA, 16'h0000, 2'b10, 6);
    endtask

    task automatic fail_test(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            fail_test($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            fail_test($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flags(input string name, input flags_t exp, input flags_t act);
        if (act !== exp) begin
            fail_test($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_state(input string name, input state_t exp, input state_t act);
        if (act !== exp) begin
            fail_test($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_write_en(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_test($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            fail_test($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    always @(cpu_top_inst.control_unit_inst.cpu_properties_inst.assert_failed) begin
        if (cpu_top_inst.control_unit_inst.cpu_properties_inst.assert_failed) begin
            fail_test("an assertion in the control unit failed");
        end
    end

    task automatic preload_program;
        foreach (steps_q[i]) begin
            @(posedge i_w_clk);
            #1;
            i_w_load_en   = 1'b1;
            i_w_load_addr = mem_addr_t'(i);
            i_w_load_data = steps_q[i].word;
        end
        @(posedge i_w_clk);
        #1;
        i_w_load_en = 1'b0;
    endtask

    task automatic apply_reset;
        @(posedge i_w_clk);
        #1;
        i_w_reset = 1'b0;
        repeat (2) @(posedge i_w_clk);
        #1;
        i_w_reset = 1'b1;
    endtask

    // one cycle of reset state, then straight into fetch
    task automatic check_restart;
        @(negedge i_w_clk);
        check_state("state after reset", ST_RESET, o_w_state_disp_out);
        @(negedge i_w_clk);
        check_state("state after release", ST_FETCH, o_w_state_disp_out);
    endtask

    // entered on a falling edge with the DUT at fetch entry
    task automatic run_step(input int idx);
        step_t     st;
        string     name;
        int        cycles;
        logic      seen_we;
        reg_addr_t seen_addr;
        data_t     seen_data;
        st        = steps_q[idx];
        name      = names_q[idx];
        cycles    = 0;
        seen_we   = 1'b0;
        seen_addr = '0;
        seen_data = '0;
        do begin
            @(negedge i_w_clk);
            cycles++;
            if (o_w_reg_wr_en) begin        // store cycle
                seen_we   = 1'b1;
                seen_addr = o_w_reg_wr_addr;
                seen_data = o_w_reg_wr_data;
            end
            if (cycles > TIMEOUT_CYCLES) begin
                fail_test($sformatf("timeout: %s did not return to fetch within %0d cycles",
                                    name, TIMEOUT_CYCLES));
            end
        end while (o_w_state_disp_out != ST_FETCH);
        check_count({name, " cycles"}, st.cycles, cycles);
        check_write_en({name, " write enable"}, st.wr_en, seen_we);
        if (st.wr_en) begin
            check_addr({name, " write address"}, st.wr_addr, seen_addr);
            check_data({name, " write data"}, st.wr_data, seen_data);
        end
        check_flags({name, " flags"}, st.flags, o_w_flags);
    endtask

    initial begin
        i_w_clk       = 1'b0;
        i_w_reset     = 1'b0;
        i_w_load_en   = 1'b0;
        i_w_load_addr = '0;
        i_w_load_data = '0;
        build_table();
        preload_program();          // memory loads while the core is held
        apply_reset();
        check_restart();
        foreach (steps_q[i]) begin
            run_step(i);
        end
        apply_reset();              // registers clear, pc back to word 0
        check_restart();
        run_step(0);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- tb/cpu_properties.sv
`timescale 1ns/10ps

module cpu_properties (
    input logic            i_w_clk,
    input logic            i_w_reset,
    input logic [4:0]      i_w_bus_oe,     // alu ram regs cp am
    input logic [13:0]     i_w_strobes,    // every oe and we
    input logic            i_w_regs_we,
    input cpu_pkg::state_t i_w_state
);
    import cpu_pkg::*;

    logic assert_failed = 1'b0;    // sticky, set by any failing assertion

    one_bus_driver: assert property (@(posedge i_w_clk) $onehot0(i_w_bus_oe))
        else begin
            $error("more than one bus driver enabled");
            assert_failed = 1'b1;
        end

    store_only_write: assert property (@(posedge i_w_clk)
        i_w_regs_we |-> (i_w_state == ST_STORE))
        else begin
            $error("register write outside the store state");
            assert_failed = 1'b1;
        end

    // sync reset takes effect one edge later
    quiet_in_reset: assert property (@(posedge i_w_clk)
        !i_w_reset |=> (i_w_strobes == '0))
        else begin
            $error("strobe active during reset");
            assert_failed = 1'b1;
        end

    reset_to_fetch: assert property (@(posedge i_w_clk) disable iff (!i_w_reset)
        (i_w_state == ST_RESET) |=> (i_w_state == ST_FETCH))
        else begin
            $error("reset state not followed by fetch");
            assert_failed = 1'b1;
        end

endmodule

bind control_unit cpu_properties cpu_properties_inst (
    .i_w_clk     (i_w_clk),
    .i_w_reset   (i_w_reset),
    .i_w_bus_oe  ({o_w_alu_oe, o_w_ram_oe, o_w_regs_oe, o_w_cp_oe, o_w_am_oe}),
    .i_w_strobes ({o_w_alu_oe, o_w_ram_oe, o_w_regs_oe, o_w_regs_we, o_w_cp_oe,
                   o_w_cp_we, o_w_am_oe, o_w_am_we, o_w_ri_we, o_w_t1_oe,
                   o_w_t1_we, o_w_t2_oe, o_w_t2_we, o_w_ind_we}),
    .i_w_regs_we (o_w_regs_we),
    .i_w_state   (o_w_state_disp_out)
);

//--- design/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
    input  logic               i_w_clk,
    input  logic               i_w_reset,
    input  logic               i_w_load_en,
    input  cpu_pkg::mem_addr_t i_w_load_addr,
    input  cpu_pkg::data_t     i_w_load_data,
    output cpu_pkg::state_t    o_w_state_disp_out,
    output cpu_pkg::flags_t    o_w_flags,
    output logic               o_w_reg_wr_en,
    output cpu_pkg::reg_addr_t o_w_reg_wr_addr,
    output cpu_pkg::data_t     o_w_reg_wr_data
);
    import cpu_pkg::*;

    data_t   l_w_bus;
    data_t   l_w_alu_result;
    flags_t  l_w_alu_flags;
    data_t   l_w_ram_rdata;
    data_t   l_w_regs_rdata;
    data_t   l_w_cp;
    data_t   l_w_am;
    data_t   l_w_ri;
    data_t   l_w_t1;
    data_t   l_w_t2;
    alu_op_t l_w_alu_opcode;
    logic    l_w_alu_oe;
    logic    l_w_alu_carry;
    logic    l_w_ram_oe;
    logic    l_w_regs_oe;
    logic    l_w_cp_oe;
    logic    l_w_cp_we;
    logic    l_w_am_oe;
    logic    l_w_am_we;
    logic    l_w_ri_we;
    logic    l_w_t1_oe;
    logic    l_w_t1_we;
    logic    l_w_t2_oe;
    logic    l_w_t2_we;
    logic    l_w_ind_we;

    assign o_w_reg_wr_data = l_w_bus;     // write-back value seen in the store cycle

    control_unit control_unit_inst (
        .i_w_clk            (i_w_clk),
        .i_w_reset          (i_w_reset),
        .i_w_ri             (l_w_ri),
        .i_w_ind            (o_w_flags),
        .o_w_alu_oe         (l_w_alu_oe),
        .o_w_alu_carry      (l_w_alu_carry),
        .o_w_alu_opcode     (l_w_alu_opcode),
        .o_w_ram_oe         (l_w_ram_oe),
        .o_w_regs_addr      (o_w_reg_wr_addr),
        .o_w_regs_oe        (l_w_regs_oe),
        .o_w_regs_we        (o_w_reg_wr_en),
        .o_w_cp_oe          (l_w_cp_oe),
        .o_w_cp_we          (l_w_cp_we),
        .o_w_am_oe          (l_w_am_oe),
        .o_w_am_we          (l_w_am_we),
        .o_w_ri_we          (l_w_ri_we),
        .o_w_t1_oe          (l_w_t1_oe),
        .o_w_t1_we          (l_w_t1_we),
        .o_w_t2_oe          (l_w_t2_oe),
        .o_w_t2_we          (l_w_t2_we),
        .o_w_ind_we         (l_w_ind_we),
        .o_w_state_disp_out (o_w_state_disp_out)
    );

    alu alu_inst (
        .i_w_a      (l_w_t1),
        .i_w_b      (l_w_t2),
        .i_w_a_oe   (l_w_t1_oe),
        .i_w_b_oe   (l_w_t2_oe),
        .i_w_carry  (l_w_alu_carry),
        .i_w_opcode (l_w_alu_opcode),
        .o_w_result (l_w_alu_result),
        .o_w_flags  (l_w_alu_flags)
    );

    register_file register_file_inst (
        .i_w_clk   (i_w_clk),
        .i_w_reset (i_w_reset),
        .i_w_addr  (o_w_reg_wr_addr),
        .i_w_we    (o_w_reg_wr_en),
        .i_w_bus   (l_w_bus),
        .o_w_rdata (l_w_regs_rdata)
    );

    program_memory program_memory_inst (
        .i_w_clk       (i_w_clk),
        .i_w_reset     (i_w_reset),
        .i_w_bus       (l_w_bus),
        .i_w_am_we     (l_w_am_we),
        .i_w_load_en   (i_w_load_en),
        .i_w_load_addr (i_w_load_addr),
        .i_w_load_data (i_w_load_data),
        .o_w_am        (l_w_am),
        .o_w_rdata     (l_w_ram_rdata)
    );

    datapath_regs datapath_regs_inst (
        .i_w_clk       (i_w_clk),
        .i_w_reset     (i_w_reset),
        .i_w_bus       (l_w_bus),
        .i_w_alu_flags (l_w_alu_flags),
        .i_w_cp_we     (l_w_cp_we),
        .i_w_ri_we     (l_w_ri_we),
        .i_w_t1_we     (l_w_t1_we),
        .i_w_t2_we     (l_w_t2_we),
        .i_w_ind_we    (l_w_ind_we),
        .o_w_cp        (l_w_cp),
        .o_w_ri        (l_w_ri),
        .o_w_t1        (l_w_t1),
        .o_w_t2        (l_w_t2),
        .o_w_ind       (o_w_flags)
    );

    bus_mux bus_mux_inst (
        .i_w_alu     (l_w_alu_result),
        .i_w_alu_oe  (l_w_alu_oe),
        .i_w_ram     (l_w_ram_rdata),
        .i_w_ram_oe  (l_w_ram_oe),
        .i_w_regs    (l_w_regs_rdata),
        .i_w_regs_oe (l_w_regs_oe),
        .i_w_cp      (l_w_cp),
        .i_w_cp_oe   (l_w_cp_oe),
        .i_w_am      (l_w_am),
        .i_w_am_oe   (l_w_am_oe),
        .o_w_bus     (l_w_bus)
    );

endmodule

//--- design/control_unit.sv
`timescale 1ns/10ps

module control_unit (
    input  logic               i_w_clk,
    input  logic               i_w_reset,
    input  cpu_pkg::data_t     i_w_ri,
    input  cpu_pkg::flags_t    i_w_ind,
    output logic               o_w_alu_oe,
    output logic               o_w_alu_carry,
    output cpu_pkg::alu_op_t   o_w_alu_opcode,
    output logic               o_w_ram_oe,
    output cpu_pkg::reg_addr_t o_w_regs_addr,
    output logic               o_w_regs_oe,
    output logic               o_w_regs_we,
    output logic               o_w_cp_oe,
    output logic               o_w_cp_we,
    output logic               o_w_am_oe,
    output logic               o_w_am_we,
    output logic               o_w_ri_we,
    output logic               o_w_t1_oe,
    output logic               o_w_t1_we,
    output logic               o_w_t2_oe,
    output logic               o_w_t2_we,
    output logic               o_w_ind_we,
    output cpu_pkg::state_t    o_w_state_disp_out
);
    import cpu_pkg::*;

    logic [6:0] l_w_cop;
    logic [1:0] l_w_mod;
    reg_addr_t  l_w_rg;
    reg_addr_t  l_w_rm;
    logic       l_w_is_1op;
    logic       l_w_is_2op;

    state_t     l_r_state = ST_RESET;
    state_t     l_r_state_next;
    state_t     l_r_dec_exec;
    state_t     l_r_dec_store;       // store or straight to pc increment
    logic       l_r_dec_d;
    reg_addr_t  l_r_dec_rg;

    assign l_w_cop = i_w_ri[COP_MSB:COP_LSB];
    assign l_w_mod = i_w_ri[MOD_MSB:MOD_LSB];
    assign l_w_rg  = i_w_ri[RG_MSB:RG_LSB];
    assign l_w_rm  = i_w_ri[RM_MSB:RM_LSB];

    // only register-direct forms are decoded
    assign l_w_is_1op = (l_w_cop[6:3] == PFX_1OP) && (l_w_mod == 2'b11);
    assign l_w_is_2op = (l_w_cop[6:4] == PFX_2OP) && (l_w_mod == 2'b11);

    always_ff @(posedge i_w_clk) begin
        if (!i_w_reset) begin
            l_r_state     <= ST_RESET;
            l_r_dec_exec  <= ST_RESET;
            l_r_dec_store <= ST_RESET;
            l_r_dec_d     <= 1'b0;
            l_r_dec_rg    <= '0;
        end else begin
            l_r_state <= l_r_state_next;
            if (l_r_state == ST_DECODE) begin
                l_r_dec_exec  <= l_w_is_1op ? ST_EXEC_1OP : ST_EXEC_2OP;
                l_r_dec_store <= (l_w_is_1op || l_w_cop[COP_STORE_BIT]) ? ST_STORE : ST_INC_CP;
                l_r_dec_d     <= l_w_is_2op & i_w_ri[D_BIT];   // one-operand acts on rm
                l_r_dec_rg    <= l_w_rg;
            end
        end
    end

    always_comb begin
        l_r_state_next = ST_RESET;
        o_w_alu_oe     = 1'b0;
        o_w_alu_carry  = 1'b0;
        o_w_alu_opcode = ALU_ADC;
        o_w_ram_oe     = 1'b0;
        o_w_regs_addr  = '0;
        o_w_regs_oe    = 1'b0;
        o_w_regs_we    = 1'b0;
        o_w_cp_oe      = 1'b0;
        o_w_cp_we      = 1'b0;
        o_w_am_oe      = 1'b0;
        o_w_am_we      = 1'b0;
        o_w_ri_we      = 1'b0;
        o_w_t1_oe      = 1'b0;
        o_w_t1_we      = 1'b0;
        o_w_t2_oe      = 1'b0;
        o_w_t2_we      = 1'b0;
        o_w_ind_we     = 1'b0;

        case (l_r_state)
            ST_RESET: l_r_state_next = ST_FETCH;

            ST_FETCH: begin
                o_w_cp_oe      = 1'b1;       // pc into address latch
                o_w_am_we      = 1'b1;
                l_r_state_next = ST_FETCH + 8'd1;
            end

            ST_FETCH + 8'd1: begin
                o_w_am_oe      = 1'b1;
                l_r_state_next = ST_FETCH + 8'd2;
            end

            ST_FETCH + 8'd2: begin
                o_w_ram_oe     = 1'b1;       // word into ri
                o_w_ri_we      = 1'b1;
                l_r_state_next = ST_DECODE;
            end

            // anything else goes straight to the pc increment
            ST_DECODE: l_r_state_next = l_w_is_1op ? ST_LOAD_DST :
                                        (l_w_is_2op ? ST_LOAD_SRC : ST_INC_CP);

            ST_LOAD_SRC: begin
                o_w_regs_addr  = l_r_dec_d ? l_w_rm : l_r_dec_rg;
                o_w_regs_oe    = 1'b1;
                o_w_t2_we      = 1'b1;
                l_r_state_next = ST_LOAD_DST;
            end

            ST_LOAD_DST: begin
                o_w_regs_addr  = l_r_dec_d ? l_r_dec_rg : l_w_rm;
                o_w_regs_oe    = 1'b1;
                o_w_t1_we      = 1'b1;
                l_r_state_next = l_r_dec_exec;
            end

            ST_EXEC_1OP: begin
                o_w_t1_oe = 1'b1;
                case (l_w_cop[2:0])
                    3'b000: begin                        // inc
                        o_w_alu_opcode = ALU_ADC;
                        o_w_alu_carry  = 1'b1;
                    end
                    3'b001: begin                        // dec
                        o_w_alu_opcode = ALU_SBB1;
                        o_w_alu_carry  = 1'b1;
                    end
                    3'b010:  o_w_alu_opcode = ALU_SBB2;   // neg, 0 - t1
                    3'b011:  o_w_alu_opcode = ALU_NOT;
                    3'b100:  o_w_alu_opcode = ALU_SHL;
                    3'b101:  o_w_alu_opcode = ALU_SHR;
                    default: o_w_alu_opcode = ALU_SAR;
                endcase
                o_w_alu_oe     = 1'b1;
                o_w_t1_we      = 1'b1;
                o_w_ind_we     = 1'b1;
                l_r_state_next = l_r_dec_store;
            end

            ST_EXEC_2OP: begin
                o_w_t1_oe = 1'b1;
                o_w_t2_oe = 1'b1;
                case (l_w_cop[2:0])
                    3'b000:  o_w_alu_opcode = ALU_ADC;    // add
                    3'b001: begin                        // adc
                        o_w_alu_opcode = ALU_ADC;
                        o_w_alu_carry  = i_w_ind.carry;
                    end
                    3'b010:  o_w_alu_opcode = ALU_SBB1;   // sub / cmp
                    3'b011: begin                        // sbb
                        o_w_alu_opcode = ALU_SBB1;
                        o_w_alu_carry  = i_w_ind.carry;
                    end
                    3'b100:  o_w_alu_opcode = ALU_AND;    // and / test
                    3'b101:  o_w_alu_opcode = ALU_OR;
                    default: o_w_alu_opcode = ALU_XOR;
                endcase
                o_w_alu_oe     = 1'b1;
                o_w_t1_we      = 1'b1;
                o_w_ind_we     = 1'b1;
                l_r_state_next = l_r_dec_store;
            end

            ST_STORE: begin
                o_w_t1_oe      = 1'b1;       // t1 or 0 passes the result through
                o_w_alu_opcode = ALU_OR;
                o_w_alu_oe     = 1'b1;
                o_w_regs_addr  = l_r_dec_d ? l_r_dec_rg : l_w_rm;
                o_w_regs_we    = 1'b1;
                l_r_state_next = ST_INC_CP;
            end

            ST_INC_CP: begin
                o_w_cp_oe      = 1'b1;
                o_w_t1_we      = 1'b1;
                l_r_state_next = ST_INC_CP + 8'd1;
            end

            ST_INC_CP + 8'd1: begin
                o_w_t1_oe      = 1'b1;       // pc + 0 + 1
                o_w_alu_carry  = 1'b1;
                o_w_alu_oe     = 1'b1;
                o_w_cp_we      = 1'b1;
                l_r_state_next = ST_FETCH;
            end

            default: l_r_state_next = ST_RESET;
        endcase
    end

    assign o_w_state_disp_out = l_r_state;

endmodule

//--- design/bus_mux.sv
`timescale 1ns/10ps

module bus_mux (
    input  cpu_pkg::data_t i_w_alu,
    input  logic           i_w_alu_oe,
    input  cpu_pkg::data_t i_w_ram,
    input  logic           i_w_ram_oe,
    input  cpu_pkg::data_t i_w_regs,
    input  logic           i_w_regs_oe,
    input  cpu_pkg::data_t i_w_cp,
    input  logic           i_w_cp_oe,
    input  cpu_pkg::data_t i_w_am,
    input  logic           i_w_am_oe,
    output cpu_pkg::data_t o_w_bus
);
    import cpu_pkg::*;

    // enables are one-hot from the control unit, so an and-or is enough
    assign o_w_bus = ({DATA_WIDTH{i_w_alu_oe}}  & i_w_alu)
                   | ({DATA_WIDTH{i_w_ram_oe}}  & i_w_ram)
                   | ({DATA_WIDTH{i_w_regs_oe}} & i_w_regs)
                   | ({DATA_WIDTH{i_w_cp_oe}}   & i_w_cp)
                   | ({DATA_WIDTH{i_w_am_oe}}   & i_w_am);   // zero when idle

endmodule

//--- design/datapath_regs.sv
`timescale 1ns/10ps

module datapath_regs (
    input  logic            i_w_clk,
    input  logic            i_w_reset,
    input  cpu_pkg::data_t  i_w_bus,
    input  cpu_pkg::flags_t i_w_alu_flags,
    input  logic            i_w_cp_we,
    input  logic            i_w_ri_we,
    input  logic            i_w_t1_we,
    input  logic            i_w_t2_we,
    input  logic            i_w_ind_we,
    output cpu_pkg::data_t  o_w_cp,
    output cpu_pkg::data_t  o_w_ri,
    output cpu_pkg::data_t  o_w_t1,
    output cpu_pkg::data_t  o_w_t2,
    output cpu_pkg::flags_t o_w_ind
);
    import cpu_pkg::*;

    always_ff @(posedge i_w_clk) begin
        if (!i_w_reset) begin
            o_w_cp  <= '0;          // execution restarts at word 0
            o_w_ri  <= '0;
            o_w_t1  <= '0;
            o_w_t2  <= '0;
            o_w_ind <= flags_t'(0);
        end else begin
            if (i_w_cp_we) begin
                o_w_cp <= i_w_bus;
            end
            if (i_w_ri_we) begin
                o_w_ri <= i_w_bus;
            end
            if (i_w_t1_we) begin
                o_w_t1 <= i_w_bus;  // destination operand / result
            end
            if (i_w_t2_we) begin
                o_w_t2 <= i_w_bus;  // source operand
            end
            if (i_w_ind_we) begin
                o_w_ind <= i_w_alu_flags;
            end
        end
    end

endmodule

//--- design/program_memory.sv
`timescale 1ns/10ps

module program_memory (
    input  logic               i_w_clk,
    input  logic               i_w_reset,
    input  cpu_pkg::data_t     i_w_bus,
    input  logic               i_w_am_we,
    input  logic               i_w_load_en,
    input  cpu_pkg::mem_addr_t i_w_load_addr,
    input  cpu_pkg::data_t     i_w_load_data,
    output cpu_pkg::data_t     o_w_am,
    output cpu_pkg::data_t     o_w_rdata
);
    import cpu_pkg::*;

    data_t l_r_am;                  // address latch
    data_t l_r_mem [MEM_DEPTH];

    always_ff @(posedge i_w_clk) begin
        if (!i_w_reset) begin
            l_r_am <= '0;
        end else if (i_w_am_we) begin
            l_r_am <= i_w_bus;
        end
    end

    // preload works in and out of reset
    always_ff @(posedge i_w_clk) begin
        if (i_w_load_en) begin
            l_r_mem[i_w_load_addr] <= i_w_load_data;
        end
    end

    assign o_w_am    = l_r_am;
    assign o_w_rdata = l_r_mem[mem_addr_t'(l_r_am)];    // low address bits

endmodule

//--- design/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic               i_w_clk,
    input  logic               i_w_reset,
    input  cpu_pkg::reg_addr_t i_w_addr,
    input  logic               i_w_we,
    input  cpu_pkg::data_t     i_w_bus,
    output cpu_pkg::data_t     o_w_rdata
);
    import cpu_pkg::*;

    data_t l_r_regs [NUM_REGS];     // ra rb rc is xa xb ba bb

    always_ff @(posedge i_w_clk) begin
        if (!i_w_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                l_r_regs[i] <= '0;
            end
        end else if (i_w_we) begin
            l_r_regs[i_w_addr] <= i_w_bus;
        end
    end

    assign o_w_rdata = l_r_regs[i_w_addr];    // same address for read and write

endmodule

//--- design/alu.sv
`timescale 1ns/10ps

module alu (
    input  cpu_pkg::data_t   i_w_a,
    input  cpu_pkg::data_t   i_w_b,
    input  logic             i_w_a_oe,
    input  logic             i_w_b_oe,
    input  logic             i_w_carry,
    input  cpu_pkg::alu_op_t i_w_opcode,
    output cpu_pkg::data_t   o_w_result,
    output cpu_pkg::flags_t  o_w_flags
);
    import cpu_pkg::*;

    data_t               l_w_a;
    data_t               l_w_b;
    logic [DATA_WIDTH:0] l_w_cin;
    logic [DATA_WIDTH:0] l_w_res;    // carry out on top

    assign l_w_a   = i_w_a_oe ? i_w_a : '0;
    assign l_w_b   = i_w_b_oe ? i_w_b : '0;
    assign l_w_cin = {{DATA_WIDTH{1'b0}}, i_w_carry};

    always_comb begin
        case (i_w_opcode)
            ALU_ADC:  l_w_res = {1'b0, l_w_a} + {1'b0, l_w_b} + l_w_cin;
            ALU_SBB1: l_w_res = {1'b0, l_w_a} - {1'b0, l_w_b} - l_w_cin;  // msb is borrow
            ALU_SBB2: l_w_res = {1'b0, l_w_b} - {1'b0, l_w_a} - l_w_cin;
            ALU_NOT:  l_w_res = {1'b0, ~l_w_a};
            ALU_AND:  l_w_res = {1'b0, l_w_a & l_w_b};
            ALU_OR:   l_w_res = {1'b0, l_w_a | l_w_b};
            ALU_XOR:  l_w_res = {1'b0, l_w_a ^ l_w_b};
            ALU_SHL:  l_w_res = {l_w_a, 1'b0};
            ALU_SHR:  l_w_res = {l_w_a[0], 1'b0, l_w_a[DATA_WIDTH-1:1]};
            ALU_SAR:  l_w_res = {l_w_a[0], l_w_a[DATA_WIDTH-1], l_w_a[DATA_WIDTH-1:1]};
            default:  l_w_res = '0;
        endcase
    end

    assign o_w_result      = l_w_res[DATA_WIDTH-1:0];
    assign o_w_flags.carry = l_w_res[DATA_WIDTH];
    assign o_w_flags.zero  = (l_w_res[DATA_WIDTH-1:0] == '0);

endmodule

//--- design/cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_WIDTH = 16;
    localparam int MEM_DEPTH  = 256;
    localparam int NUM_REGS   = 8;

    typedef logic [DATA_WIDTH-1:0]        data_t;
    typedef logic [$clog2(MEM_DEPTH)-1:0] mem_addr_t;
    typedef logic [2:0]                   reg_addr_t;
    typedef logic [3:0]                   alu_op_t;
    typedef logic [7:0]                   state_t;

    typedef struct packed {
        logic zero;
        logic carry;    // bit 0, feeds adc/sbb carry-in
    } flags_t;

    localparam reg_addr_t REG_RA = 3'd0;
    localparam reg_addr_t REG_RB = 3'd1;
    localparam reg_addr_t REG_RC = 3'd2;
    localparam reg_addr_t REG_IS = 3'd3;
    localparam reg_addr_t REG_XA = 3'd4;
    localparam reg_addr_t REG_XB = 3'd5;
    localparam reg_addr_t REG_BA = 3'd6;
    localparam reg_addr_t REG_BB = 3'd7;

    localparam alu_op_t ALU_ADC  = 4'd0;
    localparam alu_op_t ALU_SBB1 = 4'd1;    // a - b - c
    localparam alu_op_t ALU_SBB2 = 4'd2;    // b - a - c
    localparam alu_op_t ALU_NOT  = 4'd3;
    localparam alu_op_t ALU_AND  = 4'd4;
    localparam alu_op_t ALU_OR   = 4'd5;
    localparam alu_op_t ALU_XOR  = 4'd6;
    localparam alu_op_t ALU_SHL  = 4'd7;
    localparam alu_op_t ALU_SHR  = 4'd8;
    localparam alu_op_t ALU_SAR  = 4'd9;

    localparam state_t ST_RESET    = 8'h00;
    localparam state_t ST_FETCH    = 8'h10;  // 3 cycles, 10..12
    localparam state_t ST_DECODE   = 8'h20;
    localparam state_t ST_LOAD_SRC = 8'h40;
    localparam state_t ST_LOAD_DST = 8'h50;
    localparam state_t ST_EXEC_1OP = 8'h70;
    localparam state_t ST_EXEC_2OP = 8'h74;
    localparam state_t ST_STORE    = 8'h80;
    localparam state_t ST_INC_CP   = 8'h90;  // 2 cycles, 90..91

    // instruction word fields, bit 15 is the first bit of cop
    localparam int COP_MSB       = 15;
    localparam int COP_LSB       = 9;
    localparam int D_BIT         = 8;
    localparam int MOD_MSB       = 7;
    localparam int MOD_LSB       = 6;
    localparam int RG_MSB        = 5;
    localparam int RG_LSB        = 3;
    localparam int RM_MSB        = 2;
    localparam int RM_LSB        = 0;
    localparam int COP_STORE_BIT = 3;        // cleared for compare/test

    localparam logic [3:0] PFX_1OP = 4'b0001;
    localparam logic [2:0] PFX_2OP = 3'b010;

endpackage
